//--- list.f
i2c_pkg.sv
i2c_credit_fifo.sv
i2c_req_manager.sv
i2c_start_stop_gen.sv
i2c_byte_gen.sv
i2c_line_driver.sv
i2c_master_top.sv
tb_i2c_asserts.sv
tb_i2c_master.sv

//--- run.sh
#!/bin/sh
# Build and run the I2C master testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_i2c_master -o sim_i2c
./obj_dir/sim_i2c | tee /dev/stderr | grep -F '** PASS **' > /dev/null
echo "simulation passed"

//--- tb_i2c_master.sv
`timescale 1ns/1ps

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int LIMIT = 20000;

    logic i_clk;
    logic i_rst;
    logic i_cmd_push;
    t_i2c_cmd i_cmd;
    logic o_cmd_credit;
    logic i_wr_push;
    t_byte i_wr_byte;
    logic o_wr_credit;
    logic scl_line;
    logic sda_line;
    logic o_scl_oe;
    logic o_sda_oe;
    logic o_rd_valid;
    t_byte o_rd_data;
    logic o_nack;
    logic o_busy;

    logic [31:0] lfsr = 32'hfd89_2dde;
    int errors = 0;
    int timeouts = 0;
    int cmd_cred;
    int wr_cred;
    int cmd_pulses = 0;
    int wr_pulses = 0;
    int nack_cnt = 0;
    t_byte rd_q[$];
    t_byte exp_q[$];

    // Slave model state
    t_byte seen[$];
    t_byte mem[256];
    t_byte shift;
    t_byte tx;
    t_byte ptr;
    logic slave_pull = 1'b0;
    logic scl_q = 1'b1;
    logic sda_q = 1'b1;
    logic active = 1'b0;
    logic matched;
    logic rw;
    logic sending;
    logic nacked;
    int bit_cnt;
    int byte_idx;
    int start_cnt = 0;
    int stop_cnt = 0;

    assign scl_line = !o_scl_oe;
    assign sda_line = !(o_sda_oe || slave_pull);

    i2c_master_top i_i2c_master_top (
        .i_clk(i_clk), .i_rst(i_rst), .i_cmd_push(i_cmd_push), .i_cmd(i_cmd),
        .o_cmd_credit(o_cmd_credit), .i_wr_push(i_wr_push), .i_wr_byte(i_wr_byte),
        .o_wr_credit(o_wr_credit), .i_sda(sda_line), .o_scl_oe(o_scl_oe),
        .o_sda_oe(o_sda_oe), .o_rd_valid(o_rd_valid), .o_rd_data(o_rd_data),
        .o_nack(o_nack), .o_busy(o_busy)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic int rand_bits(int n);
        int r;
        logic fb;
        r = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = (r << 1) | int'(fb);
        end
        return r;
    endfunction

    // Host credit bookkeeping
    always @(posedge i_clk) begin
        if (i_rst) begin
            cmd_cred <= CMD_FIFO_DEPTH;
            wr_cred <= WR_FIFO_DEPTH;
        end else begin
            cmd_cred <= cmd_cred - int'(i_cmd_push) + int'(o_cmd_credit);
            wr_cred <= wr_cred - int'(i_wr_push) + int'(o_wr_credit);
            cmd_pulses <= cmd_pulses + int'(o_cmd_credit);
            wr_pulses <= wr_pulses + int'(o_wr_credit);
        end
    end

    always @(negedge i_clk) begin
        if (!i_rst && o_rd_valid) rd_q.push_back(o_rd_data);
        if (!i_rst && o_nack) nack_cnt++;
    end

    // I2C slave at 7'h3c; bits taken on SCL rise, SDA driven after SCL fall
    always @(negedge i_clk) begin
        if (scl_line && scl_q && sda_q && !sda_line) begin
            start_cnt++;
            active = 1'b1;
            bit_cnt = 0;
            byte_idx = 0;
            matched = 1'b0;
            sending = 1'b0;
            nacked = 1'b0;
            slave_pull <= 1'b0;
        end else if (scl_line && scl_q && !sda_q && sda_line) begin
            stop_cnt++;
            active = 1'b0;
            slave_pull <= 1'b0;
        end else if (active && scl_line && !scl_q) begin
            if (bit_cnt < 8) shift = {shift[6:0], sda_line};
            else if (sending && sda_line) nacked = 1'b1;
            bit_cnt++;
        end else if (active && !scl_line && scl_q) begin
            if (bit_cnt == 8) begin
                if (sending) begin
                    slave_pull <= 1'b0;
                end else begin
                    if (byte_idx == 0) begin
                        matched = (shift[7:1] == 7'h3c);
                        rw = shift[0];
                        seen.push_back(shift);
                    end else if (matched) begin
                        seen.push_back(shift);
                        if (byte_idx == 1) begin
                            ptr = shift;
                        end else begin
                            mem[ptr] = shift;
                            ptr = ptr + 8'd1;
                        end
                    end
                    slave_pull <= matched;
                end
            end else if (bit_cnt == 9) begin
                bit_cnt = 0;
                byte_idx++;
                sending = matched && rw && (byte_idx >= 2) && !nacked;
                if (sending) begin
                    tx = mem[ptr];
                    ptr = ptr + 8'd1;
                    slave_pull <= !tx[7];
                end else begin
                    slave_pull <= 1'b0;
                end
            end else if (sending) begin
                slave_pull <= !tx[7-bit_cnt];
            end
        end
        scl_q = scl_line;
        sda_q = sda_line;
    end

    task automatic check_byte(string name, t_byte got, t_byte exp);
        assert (got == exp) else begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_int(string name, int got, int exp);
        assert (got == exp) else begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic push_cmd(logic we, logic sccb, t_slave_addr addr, t_byte rg, int burst);
        int t;
        t = 0;
        while (cmd_cred == 0 && t < LIMIT) begin
            @(negedge i_clk);
            t++;
        end
        if (t >= LIMIT) begin
            timeouts++;
            $display("Timeout: no command credit came back");
        end else begin
            i_cmd.we = we;
            i_cmd.sccb_mode = sccb;
            i_cmd.addr_slave = addr;
            i_cmd.addr_reg = rg;
            i_cmd.burst_num = t_burst'(burst);
            i_cmd_push = 1'b1;
            @(negedge i_clk);
            i_cmd_push = 1'b0;
        end
    endtask

    task automatic push_wr(t_byte data);
        int t;
        t = 0;
        while (wr_cred == 0 && t < LIMIT) begin
            @(negedge i_clk);
            t++;
        end
        if (t >= LIMIT) begin
            timeouts++;
            $display("Timeout: no write byte credit came back");
        end else begin
            i_wr_byte = data;
            i_wr_push = 1'b1;
            @(negedge i_clk);
            i_wr_push = 1'b0;
        end
    endtask

    // All credits home and no transaction running
    task automatic wait_idle();
        int t;
        t = 0;
        while (!(cmd_cred == CMD_FIFO_DEPTH && wr_cred == WR_FIFO_DEPTH && !o_busy)
               && t < LIMIT) begin
            @(negedge i_clk);
            t++;
        end
        if (t >= LIMIT) begin
            timeouts++;
            $display("Timeout: transaction did not finish");
        end
    endtask

    task automatic write_burst(t_byte rg, int burst);
        t_byte d;
        push_cmd(1'b1, 1'b0, 7'h3c, rg, burst);
        for (int i = 0; i <= burst; i++) begin
            d = t_byte'(rand_bits(8));
            exp_q.push_back(d);
            push_wr(d);
        end
    endtask

    task automatic check_reads();
        check_int("rd_count", rd_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size() && i < rd_q.size(); i++) begin
            check_byte("o_rd_data", rd_q[i], exp_q[i]);
        end
    endtask

    initial begin
        int burst;
        int s0;
        int p0;
        int c0;
        int w0;
        t_byte rg;
        t_byte rg2;
        i_rst = 1'b1;
        i_cmd_push = 1'b0;
        i_cmd = '0;
        i_wr_push = 1'b0;
        i_wr_byte = '0;
        repeat (16) @(negedge i_clk);
        i_rst = 1'b0;
        check_int("o_scl_oe", int'(o_scl_oe), 0);
        check_int("o_sda_oe", int'(o_sda_oe), 0);

        // Write burst
        burst = rand_bits(3);
        rg = t_byte'(rand_bits(8));
        seen.delete();
        write_burst(rg, burst);
        wait_idle();
        check_int("seen_count", seen.size(), burst + 3);
        if (seen.size() == burst + 3) begin
            check_byte("addr_byte", seen[0], 8'h78);
            check_byte("reg_byte", seen[1], rg);
            for (int i = 0; i <= burst; i++) check_byte("wr_byte", seen[i+2], exp_q[i]);
        end

        // Read back the same registers
        rd_q.delete();
        push_cmd(1'b0, 1'b0, 7'h3c, rg, burst);
        wait_idle();
        check_reads();

        // Address not acknowledged
        seen.delete();
        rd_q.delete();
        push_cmd(1'b0, 1'b0, 7'h21, rg, 2);
        wait_idle();
        check_int("nack_cnt", nack_cnt, 1);
        check_int("seen_count", seen.size(), 1);
        check_int("rd_count", rd_q.size(), 0);
        check_int("o_scl_oe", int'(o_scl_oe), 0);
        check_int("o_sda_oe", int'(o_sda_oe), 0);

        // SCCB allows one data byte only
        seen.delete();
        exp_q.delete();
        s0 = stop_cnt;
        rg = t_byte'(rand_bits(8));
        push_cmd(1'b1, 1'b1, 7'h3c, rg, 3);
        exp_q.push_back(t_byte'(rand_bits(8)));
        push_wr(exp_q[0]);
        wait_idle();
        check_int("seen_count", seen.size(), 3);
        if (seen.size() == 3) check_byte("sccb_byte", seen[2], exp_q[0]);
        check_int("stop_cnt", stop_cnt - s0, 1);

        // Full credit use, four commands joined by repeated STARTs
        exp_q.delete();
        rd_q.delete();
        s0 = start_cnt;
        p0 = stop_cnt;
        c0 = cmd_pulses;
        w0 = wr_pulses;
        rg = t_byte'(rand_bits(8));
        rg2 = rg + 8'h40;
        push_cmd(1'b1, 1'b0, 7'h3c, rg, 1);
        push_cmd(1'b0, 1'b0, 7'h3c, rg, 1);
        push_cmd(1'b1, 1'b0, 7'h3c, rg2, 1);
        push_cmd(1'b0, 1'b0, 7'h3c, rg2, 1);
        for (int i = 0; i < 4; i++) begin
            exp_q.push_back(t_byte'(rand_bits(8)));
            push_wr(exp_q[i]);
        end
        wait_idle();
        check_reads();
        check_int("cmd_credits", cmd_pulses - c0, 4);
        check_int("wr_credits", wr_pulses - w0, 4);
        check_int("start_cnt", start_cnt - s0, 4);
        check_int("stop_cnt", stop_cnt - p0, 1);

        $display("errors=%0d timeouts=%0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- tb_i2c_asserts.sv
`timescale 1ns/1ps

module tb_i2c_asserts (
    input logic                 i_clk,
    input logic                 i_rst,
    input logic                 i_cmd_push,
    input logic                 i_cmd_credit,
    input logic                 i_wr_push,
    input logic                 i_wr_credit,
    input logic                 i_sda,
    input logic                 i_scl_oe,
    input logic                 i_sda_oe,
    input logic                 i_rd_valid,
    input logic                 i_nack,
    input logic                 i_busy,
    input i2c_pkg::t_gen_states i_active_gen
);
    import i2c_pkg::*;

    int cmd_cred;
    int wr_cred;

    // Credits the host holds, as seen at the DUT ports
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cmd_cred <= CMD_FIFO_DEPTH;
            wr_cred <= WR_FIFO_DEPTH;
        end else begin
            cmd_cred <= cmd_cred - int'(i_cmd_push) + int'(i_cmd_credit);
            wr_cred <= wr_cred - int'(i_wr_push) + int'(i_wr_credit);
        end
    end

    a_reset_quiet: assert property (@(posedge i_clk) $past(i_rst) |->
        !i_scl_oe && !i_sda_oe && !i_cmd_credit && !i_wr_credit
        && !i_rd_valid && !i_nack && !i_busy)
        else $error("outputs active during reset");

    // SDA may only move with SCL high while START/STOP owns the lines
    a_sda_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (!i_scl_oe && $past(!i_scl_oe) && (i_sda != $past(i_sda))) |->
        (i_active_gen == START || i_active_gen == STOP))
        else $error("SDA changed while SCL high outside START/STOP");

    // Credits held stay between zero and the FIFO depth
    a_cmd_credit: assert property (@(posedge i_clk) disable iff (i_rst)
        (cmd_cred <= CMD_FIFO_DEPTH) && (!i_cmd_push || cmd_cred > 0))
        else $error("command credit count out of range");

    a_wr_credit: assert property (@(posedge i_clk) disable iff (i_rst)
        (wr_cred <= WR_FIFO_DEPTH) && (!i_wr_push || wr_cred > 0))
        else $error("write byte credit count out of range");

    a_rd_in_busy: assert property (@(posedge i_clk) disable iff (i_rst)
        i_rd_valid |-> i_busy)
        else $error("read data outside a transaction");

endmodule

bind i2c_master_top tb_i2c_asserts i_asserts (
    .i_clk(i_clk), .i_rst(i_rst), .i_cmd_push(i_cmd_push), .i_cmd_credit(o_cmd_credit),
    .i_wr_push(i_wr_push), .i_wr_credit(o_wr_credit), .i_sda(i_sda),
    .i_scl_oe(o_scl_oe), .i_sda_oe(o_sda_oe), .i_rd_valid(o_rd_valid),
    .i_nack(o_nack), .i_busy(o_busy), .i_active_gen(active_gen)
);

//--- i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_cmd_push,
    input  i2c_pkg::t_i2c_cmd i_cmd,
    output logic              o_cmd_credit,
    input  logic              i_wr_push,
    input  i2c_pkg::t_byte    i_wr_byte,
    output logic              o_wr_credit,
    input  logic              i_sda,
    output logic              o_scl_oe,
    output logic              o_sda_oe,
    output logic              o_rd_valid,
    output i2c_pkg::t_byte    o_rd_data,
    output logic              o_nack,
    output logic              o_busy
);
    import i2c_pkg::*;

    t_i2c_cmd    cmd_data;
    logic        cmd_valid;
    logic        cmd_pop;
    t_byte       wr_data;
    logic        wr_valid;
    logic        wr_pop;
    t_gen_states active_gen;
    logic        req_valid;
    t_byte       req_byte;
    logic        req_we;
    logic        req_last;
    logic        ss_req;
    logic        ss_ready;
    logic        ss_done;
    logic        ss_scl;
    logic        ss_sda;
    logic        byte_req;
    logic        byte_ready;
    logic        byte_scl;
    logic        byte_sda;
    logic        wr_ack;
    logic        wr_nack;
    logic        sda_sync;

    // Request goes to the generator named by active_gen
    assign ss_req = req_valid && (active_gen == START || active_gen == STOP);
    assign byte_req = req_valid && (active_gen == BYTE);

    i2c_credit_fifo #(.WIDTH($bits(t_i2c_cmd)), .DEPTH(CMD_FIFO_DEPTH)) i_cmd_fifo (
        .i_clk(i_clk), .i_rst(i_rst), .i_push(i_cmd_push), .i_data(i_cmd),
        .i_pop(cmd_pop), .o_valid(cmd_valid), .o_data(cmd_data), .o_credit(o_cmd_credit)
    );

    i2c_credit_fifo #(.WIDTH($bits(t_byte)), .DEPTH(WR_FIFO_DEPTH)) i_wr_fifo (
        .i_clk(i_clk), .i_rst(i_rst), .i_push(i_wr_push), .i_data(i_wr_byte),
        .i_pop(wr_pop), .o_valid(wr_valid), .o_data(wr_data), .o_credit(o_wr_credit)
    );

    i2c_req_manager i_req_manager (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_cmd_valid(cmd_valid), .i_cmd(cmd_data), .o_cmd_pop(cmd_pop),
        .i_wr_valid(wr_valid), .i_wr_byte(wr_data), .o_wr_pop(wr_pop),
        .i_start_stop_ready(ss_ready), .i_start_stop_done(ss_done),
        .i_byte_ready(byte_ready), .i_wr_ack(wr_ack), .i_wr_nack(wr_nack),
        .i_rd_valid(o_rd_valid), .o_active_gen(active_gen), .o_req_valid(req_valid),
        .o_req_byte(req_byte), .o_req_we(req_we), .o_req_last_byte(req_last),
        .o_nack(o_nack), .o_busy(o_busy)
    );

    i2c_start_stop_gen i_start_stop_gen (
        .i_clk(i_clk), .i_rst(i_rst), .i_req(ss_req), .i_stop(active_gen == STOP),
        .o_ready(ss_ready), .o_done(ss_done), .o_scl(ss_scl), .o_sda(ss_sda)
    );

    i2c_byte_gen i_byte_gen (
        .i_clk(i_clk), .i_rst(i_rst), .i_req(byte_req), .i_we(req_we),
        .i_last(req_last), .i_byte(req_byte), .i_sda(sda_sync), .o_ready(byte_ready),
        .o_scl(byte_scl), .o_sda(byte_sda), .o_wr_ack(wr_ack), .o_wr_nack(wr_nack),
        .o_rd_valid(o_rd_valid), .o_rd_byte(o_rd_data)
    );

    i2c_line_driver i_line_driver (
        .i_clk(i_clk), .i_rst(i_rst), .i_active_gen(active_gen),
        .i_ss_scl(ss_scl), .i_ss_sda(ss_sda), .i_byte_scl(byte_scl), .i_byte_sda(byte_sda),
        .i_sda_pad(i_sda), .o_scl_oe(o_scl_oe), .o_sda_oe(o_sda_oe), .o_sda_sync(sda_sync)
    );

endmodule

//--- i2c_line_driver.sv
`timescale 1ns/1ps

module i2c_line_driver (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  i2c_pkg::t_gen_states i_active_gen,
    input  logic                 i_ss_scl,
    input  logic                 i_ss_sda,
    input  logic                 i_byte_scl,
    input  logic                 i_byte_sda,
    input  logic                 i_sda_pad,
    output logic                 o_scl_oe,
    output logic                 o_sda_oe,
    output logic                 o_sda_sync
);
    import i2c_pkg::*;

    logic sda_meta;

    // Generator lines are release bits; an enable pulls the line low
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_scl_oe <= 1'b0;
            o_sda_oe <= 1'b0;
        end else begin
            case (i_active_gen)
                START, STOP: begin
                    o_scl_oe <= !i_ss_scl;
                    o_sda_oe <= !i_ss_sda;
                end
                BYTE: begin
                    o_scl_oe <= !i_byte_scl;
                    o_sda_oe <= !i_byte_sda;
                end
                default: begin
                    o_scl_oe <= 1'b0;
                    o_sda_oe <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        sda_meta <= i_sda_pad;
        o_sda_sync <= sda_meta;
    end

endmodule

//--- i2c_byte_gen.sv
`timescale 1ns/1ps

module i2c_byte_gen (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_req,
    input  logic           i_we,
    input  logic           i_last,
    input  i2c_pkg::t_byte i_byte,
    input  logic           i_sda,
    output logic           o_ready,
    output logic           o_scl,
    output logic           o_sda,
    output logic           o_wr_ack,
    output logic           o_wr_nack,
    output logic           o_rd_valid,
    output i2c_pkg::t_byte o_rd_byte
);
    import i2c_pkg::*;

    logic             busy;
    logic             we_q;
    logic             last_q;
    logic             ack_q;
    t_byte            shift_q;
    logic [1:0]       qtr;
    logic [QTR_W-1:0] cnt;
    logic [3:0]       bit_cnt;
    logic             qtr_end;
    logic             finish;

    assign qtr_end = busy && (cnt == QTR_W'(CLK_DIV - 1));
    assign finish = qtr_end && (qtr == 2'd3) && (bit_cnt == 4'd8);

    assign o_ready = !busy;
    assign o_rd_byte = shift_q;
    assign o_rd_valid = finish && !we_q;
    assign o_wr_ack = finish && we_q && !ack_q;
    assign o_wr_nack = finish && we_q && ack_q;

    // Quarters per bit: SCL low, high, high, low
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy <= 1'b0;
            qtr <= '0;
            cnt <= '0;
            bit_cnt <= '0;
            o_scl <= 1'b0;
            o_sda <= 1'b1;
        end else if (!busy) begin
            if (i_req) begin
                busy <= 1'b1;
                qtr <= '0;
                cnt <= '0;
                bit_cnt <= '0;
                o_scl <= 1'b0;
                o_sda <= i_we ? i_byte[7] : 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
            if (qtr_end) begin
                cnt <= '0;
                qtr <= qtr + 1'b1;
                case (qtr)
                    2'd0: o_scl <= 1'b1;
                    2'd2: o_scl <= 1'b0;
                    2'd3: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'd8) begin
                            busy <= 1'b0;
                        end else if (bit_cnt == 4'd7) begin
                            // Ninth bit: release for slave ACK, or ACK/NACK a read
                            o_sda <= we_q || last_q;
                        end else if (we_q) begin
                            o_sda <= shift_q[6];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!busy && i_req) begin
            shift_q <= i_byte;
            we_q <= i_we;
            last_q <= i_last;
        end else if (qtr_end) begin
            // Sample in the middle of the SCL high time
            if (qtr == 2'd1 && bit_cnt == 4'd8) begin
                ack_q <= i_sda;
            end else if (qtr == 2'd1 && !we_q) begin
                shift_q <= {shift_q[6:0], i_sda};
            end else if (qtr == 2'd3 && we_q) begin
                shift_q <= {shift_q[6:0], 1'b0};
            end
        end
    end

endmodule

//--- i2c_start_stop_gen.sv
`timescale 1ns/1ps

module i2c_start_stop_gen (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_req,
    input  logic i_stop,
    output logic o_ready,
    output logic o_done,
    output logic o_scl,
    output logic o_sda
);
    import i2c_pkg::*;

    logic             busy;
    logic             stop_q;
    logic [1:0]       phase;
    logic [QTR_W-1:0] cnt;
    logic             qtr_end;

    assign qtr_end = busy && (cnt == QTR_W'(CLK_DIV - 1));
    assign o_ready = !busy;
    assign o_done = qtr_end && (phase == 2'd3);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy <= 1'b0;
            stop_q <= 1'b0;
            phase <= '0;
            cnt <= '0;
            o_scl <= 1'b1;
            o_sda <= 1'b1;
        end else if (!busy) begin
            if (i_req) begin
                busy <= 1'b1;
                stop_q <= i_stop;
                phase <= '0;
                cnt <= '0;
                // SCL keeps its level; SDA set up for the coming edge
                o_sda <= !i_stop;
            end
        end else begin
            cnt <= cnt + 1'b1;
            if (qtr_end) begin
                cnt <= '0;
                phase <= phase + 1'b1;
                case (phase)
                    2'd0: o_scl <= 1'b1;
                    // START pulls SDA low, STOP releases it, both with SCL high
                    2'd1: o_sda <= stop_q;
                    2'd2: o_scl <= stop_q;
                    default: busy <= 1'b0;
                endcase
            end
        end
    end

endmodule

//--- i2c_req_manager.sv
`timescale 1ns/1ps

module i2c_req_manager (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_cmd_valid,
    input  i2c_pkg::t_i2c_cmd     i_cmd,
    output logic                  o_cmd_pop,
    input  logic                  i_wr_valid,
    input  i2c_pkg::t_byte        i_wr_byte,
    output logic                  o_wr_pop,
    input  logic                  i_start_stop_ready,
    input  logic                  i_start_stop_done,
    input  logic                  i_byte_ready,
    input  logic                  i_wr_ack,
    input  logic                  i_wr_nack,
    input  logic                  i_rd_valid,
    output i2c_pkg::t_gen_states  o_active_gen,
    output logic                  o_req_valid,
    output i2c_pkg::t_byte        o_req_byte,
    output logic                  o_req_we,
    output logic                  o_req_last_byte,
    output logic                  o_nack,
    output logic                  o_busy
);
    import i2c_pkg::*;

    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        LOAD     = 3'd1,
        CONTROL  = 3'd2,
        INIT_GEN = 3'd3,
        REQ_GEN  = 3'd4,
        WAIT_GEN = 3'd5,
        END_GEN  = 3'd6
    } t_mgr_states;

    typedef struct packed {
        t_mgr_states          state;
        t_gen_states          active_gen;
        t_gen_states          next_gen;
        t_i2c_cmd             cmd;
        t_byte                req_byte;
        logic [BURST_WIDTH:0] byte_cnt;
        logic                 last_byte;
        logic                 acked;
    } t_mgr_regs;

    t_mgr_regs r;
    t_mgr_regs n;

    logic                 gen_ready;
    logic                 gen_done;
    logic [BURST_WIDTH:0] last_idx;

    // Data bytes start at index 2, after the two address bytes
    assign last_idx = {1'b0, r.cmd.burst_num} + (BURST_WIDTH+1)'(2);

    assign o_active_gen = r.active_gen;
    assign o_req_valid = (r.state == REQ_GEN);
    assign o_req_byte = r.req_byte;
    assign o_req_we = (r.byte_cnt < (BURST_WIDTH+1)'(2)) || r.cmd.we;
    assign o_req_last_byte = r.last_byte;
    assign o_busy = (r.state != IDLE) && (r.state != LOAD);

    always_comb begin
        case (r.active_gen)
            START, STOP: begin
                gen_ready = i_start_stop_ready;
                gen_done = i_start_stop_done;
            end
            BYTE: begin
                gen_ready = i_byte_ready;
                gen_done = i_wr_ack || i_wr_nack || i_rd_valid;
            end
            default: begin
                gen_ready = 1'b0;
                gen_done = 1'b0;
            end
        endcase
    end

    always_comb begin
        n = r;
        o_cmd_pop = 1'b0;
        o_wr_pop = 1'b0;
        o_nack = 1'b0;
        case (r.state)
            IDLE: begin
                n.active_gen = NONE;
                n.state = LOAD;
            end
            LOAD: begin
                if (i_cmd_valid && i_start_stop_ready) begin
                    o_cmd_pop = 1'b1;
                    n.cmd = i_cmd;
                    n.byte_cnt = '0;
                    n.last_byte = 1'b0;
                    n.next_gen = START;
                    n.state = CONTROL;
                end
            end
            CONTROL: begin
                n.active_gen = r.next_gen;
                n.state = INIT_GEN;
                case (r.next_gen)
                    NONE: n.state = IDLE;
                    BYTE: begin
                        if (r.byte_cnt == '0) begin
                            // R/W bit is high for a read
                            n.req_byte = {r.cmd.addr_slave, ~r.cmd.we};
                        end else if (r.byte_cnt == (BURST_WIDTH+1)'(1)) begin
                            n.req_byte = r.cmd.addr_reg;
                        end else begin
                            n.last_byte = r.cmd.sccb_mode || (r.byte_cnt == last_idx);
                            if (r.cmd.we) begin
                                // Hold SCL low until write data arrives
                                if (i_wr_valid) begin
                                    o_wr_pop = 1'b1;
                                    n.req_byte = i_wr_byte;
                                end else begin
                                    n.state = CONTROL;
                                end
                            end
                        end
                    end
                    default: ;
                endcase
            end
            INIT_GEN: begin
                if (gen_ready) begin
                    n.state = REQ_GEN;
                end
            end
            REQ_GEN: n.state = WAIT_GEN;
            WAIT_GEN: begin
                if (gen_done) begin
                    n.acked = i_wr_ack;
                    n.state = END_GEN;
                end
            end
            END_GEN: begin
                n.state = CONTROL;
                case (r.active_gen)
                    START: n.next_gen = BYTE;
                    STOP:  n.next_gen = NONE;
                    BYTE: begin
                        n.byte_cnt = r.byte_cnt + 1'b1;
                        if (r.byte_cnt < (BURST_WIDTH+1)'(2)) begin
                            // Address or register byte not acknowledged
                            if (!r.acked) begin
                                o_nack = 1'b1;
                                n.next_gen = STOP;
                            end
                        end else if (r.last_byte) begin
                            if (i_cmd_valid && !r.cmd.sccb_mode) begin
                                // Next command joins with a repeated START
                                o_cmd_pop = 1'b1;
                                n.cmd = i_cmd;
                                n.byte_cnt = '0;
                                n.last_byte = 1'b0;
                                n.next_gen = START;
                            end else begin
                                n.next_gen = STOP;
                            end
                        end
                    end
                    default: n.next_gen = NONE;
                endcase
            end
            default: begin
                n.state = IDLE;
                n.active_gen = NONE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            // IDLE with no active generator
            r <= '0;
        end else begin
            r <= n;
        end
    end

endmodule

//--- i2c_credit_fifo.sv
`timescale 1ns/1ps

module i2c_credit_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_push,
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_pop,
    output logic             o_valid,
    output logic [WIDTH-1:0] o_data,
    output logic             o_credit
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    // A push while full is dropped
    assign do_push = i_push && (count != (PTR_W+1)'(DEPTH));
    assign do_pop = i_pop && o_valid;

    assign o_valid = (count != '0);
    assign o_data = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
            o_credit <= 1'b0;
        end else begin
            // One credit back per entry leaving the FIFO
            o_credit <= do_pop;
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- i2c_pkg.sv
package i2c_pkg;

    // Bus timing, in system clock cycles
    localparam int CLK_DIV = 4;
    localparam int QTR_W = $clog2(CLK_DIV);

    // Host credits, equal to the FIFO depths
    localparam int CMD_FIFO_DEPTH = 4;
    localparam int WR_FIFO_DEPTH = 8;

    localparam int BURST_WIDTH = 4;

    typedef logic [7:0] t_byte;
    typedef logic [6:0] t_slave_addr;
    typedef logic [BURST_WIDTH-1:0] t_burst;

    // One register access; burst_num + 1 data bytes
    typedef struct packed {
        logic        we;
        logic        sccb_mode;
        t_slave_addr addr_slave;
        t_byte       addr_reg;
        t_burst      burst_num;
    } t_i2c_cmd;

    // Generator that currently owns the bus lines
    typedef enum logic [1:0] {
        NONE  = 2'd0,
        START = 2'd1,
        BYTE  = 2'd2,
        STOP  = 2'd3
    } t_gen_states;

endpackage
